// ==== project.f ====
+incdir+rtl
rtl/mem_system_pkg.sv
rtl/cache_way.sv
rtl/banked_mem.sv
rtl/cache_ctrl.sv
rtl/mem_system.sv
tests/tb_mem_system.sv

// ==== rtl/banked_mem.sv ====
`include "mem_system_cfg.svh"
`default_nettype none

module banked_mem (
   input  wire                        clk,
   input  wire                        reset,
   input  wire mem_system_pkg::addr_t mem_addr,
   input  wire mem_system_pkg::word_t mem_data_in,
   input  wire                        mem_rd,
   input  wire                        mem_wr,
   output mem_system_pkg::word_t      mem_data,
   output logic                       mem_stall
);

   localparam int banks = 4;
   localparam int bank_bits = $clog2(banks);
   localparam int word_addr_bits = `MEM_WORD_BITS - 1;
   localparam int busy_bits = $clog2(`MEM_BANK_BUSY + 1);
   localparam int lat = `MEM_READ_LATENCY;

   mem_system_pkg::word_t     mem [0:(1 << word_addr_bits)-1];
   mem_system_pkg::word_t     rd_pipe [0:lat-1];
   logic [busy_bits-1:0]      busy_cnt [0:banks-1];
   logic [word_addr_bits-1:0] word_addr;
   logic [bank_bits-1:0]      bank;
   logic                      access;

   assign word_addr = mem_addr[`MEM_WORD_BITS-1:1];
   assign bank      = word_addr[bank_bits-1:0];   // Low word bits interleave
   assign mem_stall = (mem_rd || mem_wr) && (busy_cnt[bank] != '0);
   assign access    = (mem_rd || mem_wr) && !mem_stall;
   assign mem_data  = rd_pipe[lat-1];

   initial begin
      for (int i = 0; i < (1 << word_addr_bits); i++) begin
         mem[i] = '0;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int b = 0; b < banks; b++) begin
            busy_cnt[b] <= '0;
         end
      end else begin
         for (int b = 0; b < banks; b++) begin
            if (access && (bank == bank_bits'(b))) begin
               busy_cnt[b] <= busy_bits'(`MEM_BANK_BUSY);
            end else if (busy_cnt[b] != '0) begin
               busy_cnt[b] <= busy_cnt[b] - 1'b1;
            end
         end
      end
   end

   // Several reads can be in flight
   always_ff @(posedge clk) begin
      if (access && mem_wr) begin
         mem[word_addr] <= mem_data_in;
      end
      if (access && mem_rd) begin
         rd_pipe[0] <= mem[word_addr];
      end
      for (int i = 1; i < lat; i++) begin
         rd_pipe[i] <= rd_pipe[i-1];
      end
   end

endmodule

`default_nettype wire

// ==== rtl/cache_ctrl.sv ====
`include "mem_system_cfg.svh"
`default_nettype none

module cache_ctrl (
   input  wire                        clk,
   input  wire                        reset,
   input  wire                        rd,
   input  wire                        wr,
   input  wire mem_system_pkg::addr_t addr,
   input  wire                        hit,
   input  wire                        victim_dirty,
   input  wire mem_system_pkg::tag_t  victim_tag,
   input  wire                        mem_stall,
   output logic                       comp,
   output logic                       write,
   output logic                       valid_in,
   output logic                       fill_sel,
   output mem_system_pkg::word_sel_t  word_sel,
   output mem_system_pkg::addr_t      mem_addr,
   output logic                       mem_rd,
   output logic                       mem_wr,
   output logic                       stall,
   output logic                       done,
   output logic                       cache_hit,
   output logic                       err
);

   localparam int lat = `MEM_READ_LATENCY;
   localparam int sel_bits = $clog2(`MEM_LINE_WORDS);
   localparam int index_lsb = sel_bits + 1;
   localparam int tag_lsb = index_lsb + `MEM_INDEX_BITS;
   localparam mem_system_pkg::word_sel_t last_word = sel_bits'(`MEM_LINE_WORDS - 1);

   mem_system_pkg::ctrl_state_t state;
   mem_system_pkg::ctrl_state_t state_next;
   mem_system_pkg::tag_t        tag;
   mem_system_pkg::index_t      index;
   mem_system_pkg::word_sel_t   req_word;
   mem_system_pkg::word_sel_t   issue_cnt;
   mem_system_pkg::word_sel_t   ret_cnt;
   logic [lat-1:0]              inflight;   // One bit per outstanding read
   logic                        returning;
   logic                        issued;
   logic                        bad_req;

   assign tag       = addr[tag_lsb +: `MEM_TAG_BITS];
   assign index     = addr[index_lsb +: `MEM_INDEX_BITS];
   assign req_word  = addr[1 +: sel_bits];
   assign bad_req   = addr[0] || (rd && wr);
   assign returning = inflight[lat-1];
   assign issued    = (mem_rd || mem_wr) && !mem_stall;

   always_comb begin
      state_next = state;
      comp       = 1'b0;
      write      = 1'b0;
      valid_in   = 1'b0;
      fill_sel   = 1'b0;
      word_sel   = req_word;
      mem_addr   = {tag, index, issue_cnt, 1'b0};
      mem_rd     = 1'b0;
      mem_wr     = 1'b0;
      done       = 1'b0;
      cache_hit  = 1'b0;
      err        = 1'b0;
      case (state)
         mem_system_pkg::st_idle: begin
            if (rd || wr) begin
               state_next = mem_system_pkg::st_compare;
            end
         end
         mem_system_pkg::st_compare: begin
            comp = 1'b1;
            if (bad_req) begin   // Rejected, nothing written
               done       = 1'b1;
               err        = 1'b1;
               state_next = mem_system_pkg::st_idle;
            end else if (hit) begin
               write      = wr;
               done       = 1'b1;
               cache_hit  = 1'b1;
               state_next = mem_system_pkg::st_idle;
            end else if (victim_dirty) begin
               state_next = mem_system_pkg::st_write_back;
            end else begin
               state_next = mem_system_pkg::st_fill;
            end
         end
         mem_system_pkg::st_write_back: begin
            word_sel = issue_cnt;   // Victim word feeds memory write data
            mem_addr = {victim_tag, index, issue_cnt, 1'b0};
            mem_wr   = 1'b1;
            if (issued && issue_cnt == last_word) begin
               state_next = mem_system_pkg::st_fill;
            end
         end
         mem_system_pkg::st_fill, mem_system_pkg::st_fill_drain: begin
            mem_rd   = (state == mem_system_pkg::st_fill);
            word_sel = ret_cnt;
            if (returning) begin
               write    = 1'b1;
               valid_in = 1'b1;
               fill_sel = 1'b1;
            end
            if (mem_rd && issued && issue_cnt == last_word) begin
               state_next = mem_system_pkg::st_fill_drain;
            end
            if (returning && ret_cnt == last_word) begin
               state_next = mem_system_pkg::st_finish;
            end
         end
         mem_system_pkg::st_finish: begin
            comp       = 1'b1;   // Line present now, real access
            write      = wr;
            done       = 1'b1;   // Reached only after a miss so cache_hit stays low
            state_next = mem_system_pkg::st_idle;
         end
         default: state_next = mem_system_pkg::st_idle;
      endcase
   end

   assign stall = (state != mem_system_pkg::st_idle) && !done;

   always_ff @(posedge clk) begin
      if (reset) begin
         state     <= mem_system_pkg::st_idle;
         issue_cnt <= '0;
         ret_cnt   <= '0;
         inflight  <= '0;
      end else begin
         state    <= state_next;
         inflight <= (inflight << 1) | lat'(mem_rd && !mem_stall);
         if (issued) begin
            issue_cnt <= issue_cnt + 1'b1;   // Wraps to zero after a line
         end
         if (returning) begin
            ret_cnt <= ret_cnt + 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

// ==== rtl/cache_way.sv ====
`include "mem_system_cfg.svh"
`default_nettype none

module cache_way (
   input  wire                            clk,
   input  wire                            reset,
   input  wire mem_system_pkg::index_t    index,
   input  wire mem_system_pkg::tag_t      tag_in,
   input  wire mem_system_pkg::word_sel_t word_sel,
   input  wire mem_system_pkg::word_t     data_in,
   input  wire                            comp,
   input  wire                            write,
   input  wire                            valid_in,
   output mem_system_pkg::tag_t           tag_out,
   output mem_system_pkg::word_t          data_out,
   output logic                           hit,
   output logic                           dirty,
   output logic                           valid
);

   localparam int sets = 1 << `MEM_INDEX_BITS;

   mem_system_pkg::tag_t  tag_mem [0:sets-1];
   mem_system_pkg::word_t data_mem [0:sets-1][0:`MEM_LINE_WORDS-1];
   logic [sets-1:0]       valid_bits;
   logic [sets-1:0]       dirty_bits;
   logic                  cmp_write;
   logic                  fill_write;

   assign tag_out  = tag_mem[index];
   assign data_out = data_mem[index][word_sel];
   assign valid    = valid_bits[index];
   assign dirty    = dirty_bits[index];

   // Kept independent of comp so the way being filled keeps matching
   assign hit = valid && (tag_mem[index] == tag_in);

   assign cmp_write  = write && comp && hit;
   assign fill_write = write && !comp;

   always_ff @(posedge clk) begin
      if (reset) begin
         valid_bits <= '0;
         dirty_bits <= '0;
      end else if (cmp_write) begin
         dirty_bits[index] <= 1'b1;
      end else if (fill_write) begin
         valid_bits[index] <= valid_in;
         dirty_bits[index] <= 1'b0;   // Line now matches memory
      end
   end

   always_ff @(posedge clk) begin
      if (cmp_write || fill_write) begin
         data_mem[index][word_sel] <= data_in;
      end
      if (fill_write) begin
         tag_mem[index] <= tag_in;
      end
   end

endmodule

`default_nettype wire

// ==== rtl/mem_system.sv ====
`include "mem_system_cfg.svh"
`default_nettype none

module mem_system (
   input  wire                        clk,
   input  wire                        reset,
   input  wire mem_system_pkg::addr_t addr,
   input  wire mem_system_pkg::word_t data_in,
   input  wire                        rd,
   input  wire                        wr,
   output mem_system_pkg::word_t      data_out,
   output logic                       done,
   output logic                       stall,
   output logic                       cache_hit,
   output logic                       err
);

   localparam int index_lsb = $clog2(`MEM_LINE_WORDS) + 1;
   localparam int tag_lsb = index_lsb + `MEM_INDEX_BITS;

   mem_system_pkg::tag_t      tag;
   mem_system_pkg::index_t    index;
   mem_system_pkg::word_sel_t word_sel;
   mem_system_pkg::word_t     way_data_in;
   mem_system_pkg::word_t     way_data_0, way_data_1;
   mem_system_pkg::tag_t      tag_out_0, tag_out_1;
   mem_system_pkg::tag_t      victim_tag;
   mem_system_pkg::addr_t     mem_addr;
   mem_system_pkg::word_t     mem_data;
   logic comp, write, valid_in, fill_sel;
   logic hit_0, hit_1, dirty_0, dirty_1, valid_0, valid_1;
   logic write_0, write_1, valid_in_0, valid_in_1;
   logic sel, victim, hit, victim_dirty;
   logic mem_rd, mem_wr, mem_stall;

   assign tag   = addr[tag_lsb +: `MEM_TAG_BITS];
   assign index = addr[index_lsb +: `MEM_INDEX_BITS];

   assign way_data_in = fill_sel ? mem_data : data_in;

   // Hit way first, then an empty way, then the victim flop
   always_comb begin
      if (hit_0)         sel = 1'b0;
      else if (hit_1)    sel = 1'b1;
      else if (!valid_0) sel = 1'b0;
      else if (!valid_1) sel = 1'b1;
      else               sel = ~victim;
   end

   assign hit          = sel ? hit_1 : hit_0;
   assign victim_dirty = sel ? dirty_1 : dirty_0;
   assign victim_tag   = sel ? tag_out_1 : tag_out_0;
   assign data_out     = sel ? way_data_1 : way_data_0;
   assign write_0      = write && !sel;
   assign write_1      = write && sel;
   assign valid_in_0   = valid_in && !sel;
   assign valid_in_1   = valid_in && sel;

   always_ff @(posedge clk) begin
      if (reset) begin
         victim <= 1'b0;
      end else if (done) begin
         victim <= ~victim;
      end
   end

   cache_way way_0 (
      .clk(clk), .reset(reset), .index(index), .tag_in(tag), .word_sel(word_sel),
      .data_in(way_data_in), .comp(comp), .write(write_0), .valid_in(valid_in_0),
      .tag_out(tag_out_0), .data_out(way_data_0), .hit(hit_0), .dirty(dirty_0),
      .valid(valid_0)
   );

   cache_way way_1 (
      .clk(clk), .reset(reset), .index(index), .tag_in(tag), .word_sel(word_sel),
      .data_in(way_data_in), .comp(comp), .write(write_1), .valid_in(valid_in_1),
      .tag_out(tag_out_1), .data_out(way_data_1), .hit(hit_1), .dirty(dirty_1),
      .valid(valid_1)
   );

   banked_mem mem (
      .clk(clk), .reset(reset), .mem_addr(mem_addr),
      .mem_data_in(data_out),   // Write-back source is the selected way
      .mem_rd(mem_rd), .mem_wr(mem_wr), .mem_data(mem_data), .mem_stall(mem_stall)
   );

   cache_ctrl ctrl (
      .clk(clk), .reset(reset), .rd(rd), .wr(wr), .addr(addr),
      .hit(hit), .victim_dirty(victim_dirty), .victim_tag(victim_tag),
      .mem_stall(mem_stall), .comp(comp), .write(write), .valid_in(valid_in),
      .fill_sel(fill_sel), .word_sel(word_sel), .mem_addr(mem_addr),
      .mem_rd(mem_rd), .mem_wr(mem_wr), .stall(stall), .done(done),
      .cache_hit(cache_hit), .err(err)
   );

endmodule

`default_nettype wire

// ==== rtl/mem_system_cfg.svh ====
`ifndef MEM_SYSTEM_CFG_SVH
`define MEM_SYSTEM_CFG_SVH

// Data path
`define MEM_WORD_BITS 16

// Address split, tag : index : word select : alignment bit
`define MEM_TAG_BITS 5
`define MEM_INDEX_BITS 8
`define MEM_LINE_WORDS 4

// Main memory timing in cycles
`define MEM_READ_LATENCY 2
`define MEM_BANK_BUSY 4

`endif

// ==== rtl/mem_system_pkg.sv ====
`include "mem_system_cfg.svh"
`default_nettype none

package mem_system_pkg;

   typedef logic [`MEM_WORD_BITS-1:0] word_t;
   typedef logic [`MEM_WORD_BITS-1:0] addr_t;   // Byte address
   typedef logic [`MEM_TAG_BITS-1:0] tag_t;
   typedef logic [`MEM_INDEX_BITS-1:0] index_t;
   typedef logic [$clog2(`MEM_LINE_WORDS)-1:0] word_sel_t;

   // Miss handling sequence
   typedef enum logic [2:0] {
      st_idle,
      st_compare,
      st_write_back,
      st_fill,
      st_fill_drain,   // All reads issued, waiting on returns
      st_finish
   } ctrl_state_t;

endpackage

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
   --top-module tb_mem_system -f project.f
output=$(./obj_dir/Vtb_mem_system)
echo "$output"
if grep -qx "Test OK" <<< "$output"; then
   exit 0
fi
exit 1

// ==== tests/mem_stimulus.txt ====
# op (1 rd, 2 wr, 3 rd+wr)  addr  wdata  exp_data  exp_hit  exp_err, all hex
# exp_data is compared on reads without error only
2 0028 1234 0000 0 0
1 0028 0000 1234 1 0
1 002a 0000 0000 1 0
1 0030 0000 0000 0 0
1 0030 0000 0000 1 0
2 0880 a001 0000 0 0
2 1080 b002 0000 0 0
1 0880 0000 a001 1 0
1 1080 0000 b002 1 0
2 1882 c003 0000 0 0
2 2084 d004 0000 0 0
1 0880 0000 a001 0 0
1 1080 0000 b002 0 0
1 1882 0000 c003 0 0
1 2084 0000 d004 0 0
1 2084 0000 d004 1 0
1 1882 0000 c003 1 0
1 1880 0000 0000 1 0
2 0029 ffff 0000 0 1
1 0029 0000 0000 0 1
3 0028 eeee 0000 0 1
1 0028 0000 1234 1 0
3 0880 5555 0000 0 1
1 0880 0000 a001 0 0
2 0882 7777 0000 1 0
1 0882 0000 7777 1 0
2 fffe beef 0000 0 0
1 fffe 0000 beef 1 0

// ==== tests/tb_mem_system.sv ====
`default_nettype none

module tb_mem_system;
   timeunit 1ns;
   timeprecision 1ps;

   localparam string stim_file = "tests/mem_stimulus.txt";
   localparam int cycles_per_test = 60;

   logic                  clk;
   logic                  reset;
   mem_system_pkg::addr_t addr;
   mem_system_pkg::word_t data_in;
   logic                  rd;
   logic                  wr;
   mem_system_pkg::word_t data_out;
   logic                  done;
   logic                  stall;
   logic                  cache_hit;
   logic                  err;

   // One entry per stimulus line
   logic [1:0]            op_q [$];   // Bit 0 rd, bit 1 wr
   mem_system_pkg::addr_t addr_q [$];
   mem_system_pkg::word_t wdata_q [$];
   mem_system_pkg::word_t exp_data_q [$];
   logic                  exp_hit_q [$];
   logic                  exp_err_q [$];

   int check_errors = 0;
   int tests_passed = 0;
   int tests_failed = 0;
   int cycle_limit = 0;
   int cycle_count = 0;

   mem_system mem_system_i (
      .clk(clk), .reset(reset), .addr(addr), .data_in(data_in), .rd(rd), .wr(wr),
      .data_out(data_out), .done(done), .stall(stall), .cache_hit(cache_hit), .err(err)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   task automatic check_word(input mem_system_pkg::word_t got,
                             input mem_system_pkg::word_t exp, input string what);
      if (got !== exp) begin
         $display("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
         check_errors++;
      end
   endtask

   task automatic check_flag(input logic got, input logic exp, input string what);
      if (got !== exp) begin
         $display("FAILED at %0t: %s is %b, expected %b", $time, what, got, exp);
         check_errors++;
      end
   endtask

   task automatic load_stimulus();
      int          fd;
      int          n;
      string       line;
      logic [15:0] f_op, f_addr, f_wdata, f_data, f_hit, f_err;
      fd = $fopen(stim_file, "r");
      if (fd == 0) begin
         $display("Could not open the stimulus file %s", stim_file);
         check_errors++;
      end else begin
         while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 1 && line[0] != "#") begin   // Skip header and blank lines
               n = $sscanf(line, "%h %h %h %h %h %h", f_op, f_addr, f_wdata, f_data,
                           f_hit, f_err);
               if (n == 6) begin
                  op_q.push_back(f_op[1:0]);
                  addr_q.push_back(f_addr);
                  wdata_q.push_back(f_wdata);
                  exp_data_q.push_back(f_data);
                  exp_hit_q.push_back(f_hit[0]);
                  exp_err_q.push_back(f_err[0]);
               end
            end
         end
         $fclose(fd);
      end
   endtask

   function automatic string op_name(input logic [1:0] op);
      case (op)
         2'b01:   return "rd";
         2'b10:   return "wr";
         default: return "rd+wr";
      endcase
   endfunction

   task automatic tally(input string desc, input int errors_before);
      if (check_errors == errors_before) begin
         tests_passed++;
         $display("%s passed", desc);
      end else begin
         tests_failed++;
         $display("%s failed", desc);
      end
   endtask

   // Nothing should move while no request is present
   task automatic check_idle_outputs();
      int errors_before;
      errors_before = check_errors;
      repeat (3) begin
         @(negedge clk);
         check_flag(stall, 1'b0, "stall after reset");
         check_flag(done, 1'b0, "done after reset");
         check_flag(cache_hit, 1'b0, "cache_hit after reset");
         check_flag(err, 1'b0, "err after reset");
      end
      tally("test 0: idle outputs after reset", errors_before);
   endtask

   task automatic run_request(input int num);
      int   waited;
      int   errors_before;
      logic is_read;
      errors_before = check_errors;
      is_read = (op_q[num] == 2'b01);
      @(posedge clk);
      rd      <= op_q[num][0];
      wr      <= op_q[num][1];
      addr    <= addr_q[num];
      data_in <= wdata_q[num];
      waited = 0;
      do begin
         @(negedge clk);
         waited++;
         if (!done && waited > 1) begin
            check_flag(stall, 1'b1, "stall while busy");
         end
      end while (!done);
      check_flag(cache_hit, exp_hit_q[num], "cache_hit");
      check_flag(err, exp_err_q[num], "err");
      if (is_read && !exp_err_q[num]) begin
         check_word(data_out, exp_data_q[num], "read data");
      end
      @(posedge clk);
      rd <= 1'b0;   // Released the cycle after done
      wr <= 1'b0;
      tally($sformatf("test %0d: %s addr %h, %0d cycles", num + 1, op_name(op_q[num]),
                      addr_q[num], waited), errors_before);
   endtask

   initial begin
      reset   = 1'b1;
      rd      = 1'b0;
      wr      = 1'b0;
      addr    = '0;
      data_in = '0;
      load_stimulus();
      if (addr_q.size() == 0) begin
         $display("No requests were read from the stimulus file");
         check_errors++;
      end
      cycle_limit = cycles_per_test * addr_q.size();
      repeat (5) @(posedge clk);
      reset <= 1'b0;
      check_idle_outputs();
      for (int i = 0; i < addr_q.size(); i++) begin
         run_request(i);
      end
      repeat (2) @(posedge clk);
      $display("%0d tests passed, %0d tests failed", tests_passed, tests_failed);
      if (check_errors == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

   // Watchdog on total run length
   initial begin
      mem_system_pkg::ctrl_state_t st;
      wait (cycle_limit > 0);
      while (cycle_count < cycle_limit) begin
         @(posedge clk);
         cycle_count++;
      end
      st = mem_system_i.ctrl.state;
      $display("Timeout after %0d cycles waiting for done, controller state %s",
               cycle_count, st.name());
      $display("Test FAILED");
      $finish;
   end

endmodule

`default_nettype wire
